//--- compile.f
logic/l15_adapter_pkg.sv
logic/miss_request_shaper.sv
logic/port_request_slot.sv
logic/l15_request_arbiter.sv
logic/l15_response_router.sv
logic/l15_adapter.sv
tests/tb_clock_gen.sv
tests/l15_adapter_tb.sv

//--- logic/l15_adapter.sv
// Requests take at least one cycle through the slots, returns pass through in the same cycle
`timescale 1ns/1ps

module l15_adapter
  import l15_adapter_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  // I-cache miss
  input  logic                   icache_miss_valid_i,
  output logic                   icache_miss_ready_o,
  input  logic [PADDR_WIDTH-1:0] icache_miss_paddr_i,

  // D-cache read
  input  logic                   dread_valid_i,
  output logic                   dread_ready_o,
  input  logic [PADDR_WIDTH-1:0] dread_addr_i,
  input  size_t                  dread_size_i,

  // D-cache write request and data
  input  logic                   dwrite_valid_i,
  output logic                   dwrite_ready_o,
  input  logic [PADDR_WIDTH-1:0] dwrite_addr_i,
  input  size_t                  dwrite_size_i,
  input  logic                   dwdata_valid_i,
  output logic                   dwdata_ready_o,
  input  logic [DATA_WIDTH-1:0]  dwdata_i,

  // L1.5 request
  output logic                   l15_req_valid_o,
  input  logic                   l15_req_ready_i,
  output l15_rqtype_e            l15_req_type_o,
  output port_e                  l15_req_port_o,
  output logic [PADDR_WIDTH-1:0] l15_req_addr_o,
  output size_t                  l15_req_size_o,
  output logic [DATA_WIDTH-1:0]  l15_req_data_o,

  // L1.5 return
  input  logic                   l15_rtrn_valid_i,
  output logic                   l15_rtrn_ready_o,
  input  port_e                  l15_rtrn_port_i,
  input  logic [DATA_WIDTH-1:0]  l15_rtrn_data_i,

  // Responses
  output logic                   icache_resp_valid_o,
  output logic [DATA_WIDTH-1:0]  icache_resp_data_o,
  output logic                   dread_resp_valid_o,
  input  logic                   dread_resp_ready_i,
  output logic [DATA_WIDTH-1:0]  dread_resp_data_o,
  output logic                   dwrite_resp_valid_o,
  input  logic                   dwrite_resp_ready_i
);

  // Shaper to slots
  logic [NUM_PORTS-1:0]   shp_valid;
  logic [NUM_PORTS-1:0]   shp_ready;
  l15_rqtype_e            shp_type [NUM_PORTS];
  logic [PADDR_WIDTH-1:0] shp_addr [NUM_PORTS];
  size_t                  shp_size [NUM_PORTS];
  logic [DATA_WIDTH-1:0]  shp_data [NUM_PORTS];

  // Slots to arbiter
  logic [NUM_PORTS-1:0]   arb_valid;
  logic [NUM_PORTS-1:0]   arb_ready;
  l15_rqtype_e            arb_type [NUM_PORTS];
  logic [PADDR_WIDTH-1:0] arb_addr [NUM_PORTS];
  size_t                  arb_size [NUM_PORTS];
  logic [DATA_WIDTH-1:0]  arb_data [NUM_PORTS];

  miss_request_shaper i_shaper (
    .icache_miss_valid_i (icache_miss_valid_i),
    .icache_miss_ready_o (icache_miss_ready_o),
    .icache_miss_paddr_i (icache_miss_paddr_i),
    .dread_valid_i       (dread_valid_i),
    .dread_ready_o       (dread_ready_o),
    .dread_addr_i        (dread_addr_i),
    .dread_size_i        (dread_size_i),
    .dwrite_valid_i      (dwrite_valid_i),
    .dwrite_ready_o      (dwrite_ready_o),
    .dwrite_addr_i       (dwrite_addr_i),
    .dwrite_size_i       (dwrite_size_i),
    .dwdata_valid_i      (dwdata_valid_i),
    .dwdata_ready_o      (dwdata_ready_o),
    .dwdata_i            (dwdata_i),
    .slot_valid_o        (shp_valid),
    .slot_ready_i        (shp_ready),
    .slot_type_o         (shp_type),
    .slot_addr_o         (shp_addr),
    .slot_size_o         (shp_size),
    .slot_data_o         (shp_data)
  );

  // One holding slot per source port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_slot
    port_request_slot i_slot (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_valid_i  (shp_valid[p]),
      .in_ready_o  (shp_ready[p]),
      .in_type_i   (shp_type[p]),
      .in_addr_i   (shp_addr[p]),
      .in_size_i   (shp_size[p]),
      .in_data_i   (shp_data[p]),
      .out_valid_o (arb_valid[p]),
      .out_ready_i (arb_ready[p]),
      .out_type_o  (arb_type[p]),
      .out_addr_o  (arb_addr[p]),
      .out_size_o  (arb_size[p]),
      .out_data_o  (arb_data[p])
    );
  end

  l15_request_arbiter i_arbiter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (arb_valid),
    .req_ready_o     (arb_ready),
    .req_type_i      (arb_type),
    .req_addr_i      (arb_addr),
    .req_size_i      (arb_size),
    .req_data_i      (arb_data),
    .l15_req_valid_o (l15_req_valid_o),
    .l15_req_ready_i (l15_req_ready_i),
    .l15_req_type_o  (l15_req_type_o),
    .l15_req_port_o  (l15_req_port_o),
    .l15_req_addr_o  (l15_req_addr_o),
    .l15_req_size_o  (l15_req_size_o),
    .l15_req_data_o  (l15_req_data_o)
  );

  l15_response_router i_router (
    .l15_rtrn_valid_i    (l15_rtrn_valid_i),
    .l15_rtrn_ready_o    (l15_rtrn_ready_o),
    .l15_rtrn_port_i     (l15_rtrn_port_i),
    .l15_rtrn_data_i     (l15_rtrn_data_i),
    .icache_resp_valid_o (icache_resp_valid_o),
    .icache_resp_data_o  (icache_resp_data_o),
    .dread_resp_valid_o  (dread_resp_valid_o),
    .dread_resp_ready_i  (dread_resp_ready_i),
    .dread_resp_data_o   (dread_resp_data_o),
    .dwrite_resp_valid_o (dwrite_resp_valid_o),
    .dwrite_resp_ready_i (dwrite_resp_ready_i)
  );

endmodule

//--- logic/l15_adapter_pkg.sv
// Three fixed ports share one 64-bit data width, and port codes double as array indices
package l15_adapter_pkg;

  // Number of request ports feeding the L1.5 channel
  localparam int NUM_PORTS = 3;

  // Physical address width as seen by the L1.5
  localparam int PADDR_WIDTH = 40;

  // Request and return data width for every port
  localparam int DATA_WIDTH = 64;

  // log2 of the I-cache line in bytes, also its size code
  localparam int ICACHE_LINE_OFFSET = 5;

  // Source and destination ports
  typedef enum logic [1:0] {
    PORT_ICACHE = 2'd0,
    PORT_DREAD  = 2'd1,
    PORT_DWRITE = 2'd2
  } port_e;

  // Request opcodes on the L1.5 channel
  typedef enum logic [1:0] {
    RQ_IFILL = 2'd0,
    RQ_LOAD  = 2'd1,
    RQ_STORE = 2'd2
  } l15_rqtype_e;

  // log2 of the number of bytes accessed
  typedef logic [2:0] size_t;

endpackage

//--- logic/l15_request_arbiter.sv
// Round-robin over the slots; the pointer only moves when the L1.5 takes a request
`timescale 1ns/1ps

module l15_request_arbiter
  import l15_adapter_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  // From the slots
  input  logic [NUM_PORTS-1:0]   req_valid_i,
  output logic [NUM_PORTS-1:0]   req_ready_o,
  input  l15_rqtype_e            req_type_i [NUM_PORTS],
  input  logic [PADDR_WIDTH-1:0] req_addr_i [NUM_PORTS],
  input  size_t                  req_size_i [NUM_PORTS],
  input  logic [DATA_WIDTH-1:0]  req_data_i [NUM_PORTS],

  // To the L1.5
  output logic                   l15_req_valid_o,
  input  logic                   l15_req_ready_i,
  output l15_rqtype_e            l15_req_type_o,
  output port_e                  l15_req_port_o,
  output logic [PADDR_WIDTH-1:0] l15_req_addr_o,
  output size_t                  l15_req_size_o,
  output logic [DATA_WIDTH-1:0]  l15_req_data_o
);

  port_e rr_q;
  port_e grant_idx;
  logic  grant_valid;

  // Port number modulo the port count
  function automatic port_e wrap_port(input int idx);
    return port_e'(idx % NUM_PORTS);
  endfunction

  // First valid slot at or after the pointer
  always_comb begin
    port_e cand;
    grant_valid = 1'b0;
    grant_idx   = rr_q;
    for (int k = 0; k < NUM_PORTS; k++) begin
      cand = wrap_port(int'(rr_q) + k);
      if (!grant_valid && req_valid_i[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  // Only the winner sees the L1.5 ready
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      req_ready_o[i] = grant_valid && l15_req_ready_i && (int'(grant_idx) == i);
    end
  end

  assign l15_req_valid_o = grant_valid;
  assign l15_req_port_o  = grant_idx;
  assign l15_req_type_o  = req_type_i[grant_idx];
  assign l15_req_addr_o  = req_addr_i[grant_idx];
  assign l15_req_size_o  = req_size_i[grant_idx];
  assign l15_req_data_o  = req_data_i[grant_idx];

  // Next search starts just past the port that was served
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q <= PORT_ICACHE;
    end else if (grant_valid && l15_req_ready_i) begin
      rr_q <= wrap_port(int'(grant_idx) + 1);
    end
  end

endmodule

//--- logic/l15_response_router.sv
// A D-cache return is only shown to its port when that port is ready; the I-cache never stalls
`timescale 1ns/1ps

module l15_response_router
  import l15_adapter_pkg::*;
(
  // From the L1.5
  input  logic                  l15_rtrn_valid_i,
  output logic                  l15_rtrn_ready_o,
  input  port_e                 l15_rtrn_port_i,
  input  logic [DATA_WIDTH-1:0] l15_rtrn_data_i,

  // I-cache fill data
  output logic                  icache_resp_valid_o,
  output logic [DATA_WIDTH-1:0] icache_resp_data_o,

  // D-cache read data
  output logic                  dread_resp_valid_o,
  input  logic                  dread_resp_ready_i,
  output logic [DATA_WIDTH-1:0] dread_resp_data_o,

  // D-cache write acknowledge
  output logic                  dwrite_resp_valid_o,
  input  logic                  dwrite_resp_ready_i
);

  // Data fans out to both data ports while the valids select the owner
  assign icache_resp_data_o = l15_rtrn_data_i;
  assign dread_resp_data_o  = l15_rtrn_data_i;

  always_comb begin
    icache_resp_valid_o = 1'b0;
    dread_resp_valid_o  = 1'b0;
    dwrite_resp_valid_o = 1'b0;
    l15_rtrn_ready_o    = 1'b1;
    case (l15_rtrn_port_i)
      PORT_ICACHE: begin
        icache_resp_valid_o = l15_rtrn_valid_i;
      end
      PORT_DREAD: begin
        dread_resp_valid_o = l15_rtrn_valid_i & dread_resp_ready_i;
        l15_rtrn_ready_o   = dread_resp_ready_i;
      end
      PORT_DWRITE: begin
        dwrite_resp_valid_o = l15_rtrn_valid_i & dwrite_resp_ready_i;
        l15_rtrn_ready_o    = dwrite_resp_ready_i;
      end
      default: begin
        // Unknown port code is consumed and dropped
        l15_rtrn_ready_o = 1'b1;
      end
    endcase
  end

endmodule

//--- logic/miss_request_shaper.sv
// Write request and write data must be valid together, I-cache addresses are line aligned here
`timescale 1ns/1ps

module miss_request_shaper
  import l15_adapter_pkg::*;
(
  // I-cache miss
  input  logic                   icache_miss_valid_i,
  output logic                   icache_miss_ready_o,
  input  logic [PADDR_WIDTH-1:0] icache_miss_paddr_i,

  // D-cache read
  input  logic                   dread_valid_i,
  output logic                   dread_ready_o,
  input  logic [PADDR_WIDTH-1:0] dread_addr_i,
  input  size_t                  dread_size_i,

  // D-cache write request and data
  input  logic                   dwrite_valid_i,
  output logic                   dwrite_ready_o,
  input  logic [PADDR_WIDTH-1:0] dwrite_addr_i,
  input  size_t                  dwrite_size_i,
  input  logic                   dwdata_valid_i,
  output logic                   dwdata_ready_o,
  input  logic [DATA_WIDTH-1:0]  dwdata_i,

  // Common request form, one lane per slot
  output logic [NUM_PORTS-1:0]   slot_valid_o,
  input  logic [NUM_PORTS-1:0]   slot_ready_i,
  output l15_rqtype_e            slot_type_o [NUM_PORTS],
  output logic [PADDR_WIDTH-1:0] slot_addr_o [NUM_PORTS],
  output size_t                  slot_size_o [NUM_PORTS],
  output logic [DATA_WIDTH-1:0]  slot_data_o [NUM_PORTS]
);

  logic write_pair_valid;

  // I-cache fill, whole line
  assign slot_valid_o[PORT_ICACHE] = icache_miss_valid_i;
  assign icache_miss_ready_o       = slot_ready_i[PORT_ICACHE];
  assign slot_type_o[PORT_ICACHE]  = RQ_IFILL;
  assign slot_addr_o[PORT_ICACHE]  = {icache_miss_paddr_i[PADDR_WIDTH-1:ICACHE_LINE_OFFSET],
                                      {ICACHE_LINE_OFFSET{1'b0}}};
  assign slot_size_o[PORT_ICACHE]  = size_t'(ICACHE_LINE_OFFSET);
  assign slot_data_o[PORT_ICACHE]  = '0;

  // Plain load, carries no data
  assign slot_valid_o[PORT_DREAD] = dread_valid_i;
  assign dread_ready_o            = slot_ready_i[PORT_DREAD];
  assign slot_type_o[PORT_DREAD]  = RQ_LOAD;
  assign slot_addr_o[PORT_DREAD]  = dread_addr_i;
  assign slot_size_o[PORT_DREAD]  = dread_size_i;
  assign slot_data_o[PORT_DREAD]  = '0;

  // Store needs both halves; joined readies so neither half moves alone
  assign write_pair_valid          = dwrite_valid_i & dwdata_valid_i;
  assign slot_valid_o[PORT_DWRITE] = write_pair_valid;
  assign dwrite_ready_o            = slot_ready_i[PORT_DWRITE] & write_pair_valid;
  assign dwdata_ready_o            = slot_ready_i[PORT_DWRITE] & write_pair_valid;
  assign slot_type_o[PORT_DWRITE]  = RQ_STORE;
  assign slot_addr_o[PORT_DWRITE]  = dwrite_addr_i;
  assign slot_size_o[PORT_DWRITE]  = dwrite_size_i;
  assign slot_data_o[PORT_DWRITE]  = dwdata_i;

endmodule

//--- logic/port_request_slot.sv
// One entry deep; accepts while empty or while being drained in the same cycle
`timescale 1ns/1ps

module port_request_slot
  import l15_adapter_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  l15_rqtype_e            in_type_i,
  input  logic [PADDR_WIDTH-1:0] in_addr_i,
  input  size_t                  in_size_i,
  input  logic [DATA_WIDTH-1:0]  in_data_i,

  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output l15_rqtype_e            out_type_o,
  output logic [PADDR_WIDTH-1:0] out_addr_o,
  output size_t                  out_size_o,
  output logic [DATA_WIDTH-1:0]  out_data_o
);

  logic full_q;
  logic drain;
  logic fill;

  assign drain       = full_q & out_ready_i;
  assign in_ready_o  = ~full_q | drain;
  assign fill        = in_valid_i & in_ready_o;
  assign out_valid_o = full_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (fill) begin
      full_q <= 1'b1;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  // Payload captured on every accepted request
  always_ff @(posedge clk_i) begin
    if (fill) begin
      out_type_o <= in_type_i;
      out_addr_o <= in_addr_i;
      out_size_o <= in_size_i;
      out_data_o <= in_data_i;
    end
  end

endmodule

//--- tests/l15_adapter_tb.sv
// Random traffic on all three sources against an L1.5 model; stops at the first mismatch
`timescale 1ns/1ps

module l15_adapter_tb
  import l15_adapter_pkg::*;
();

  localparam int NUM_TXN = 40;
  localparam int MAX_GAP = 4;
  localparam int MAX_DELAY = 8;
  localparam logic [63:0] RTRN_KEY = 64'h5a5a_0f0f_c3c3_9696;
  localparam int WATCHDOG_NS = NUM_TXN * NUM_PORTS * (MAX_GAP + MAX_DELAY + 10) * 4 + 4000;

  logic clk, reset;
  integer seed = 32'h9927_eba7;
  int cycle = 0;
  int rr_ptr = 0;
  logic was_reset = 1'b1;
  logic rtrn_taken = 1'b0;

  logic icache_miss_valid_i, icache_miss_ready_o;
  logic [PADDR_WIDTH-1:0] icache_miss_paddr_i;
  logic dread_valid_i, dread_ready_o;
  logic [PADDR_WIDTH-1:0] dread_addr_i;
  size_t dread_size_i;
  logic dwrite_valid_i, dwrite_ready_o, dwdata_valid_i, dwdata_ready_o;
  logic [PADDR_WIDTH-1:0] dwrite_addr_i;
  size_t dwrite_size_i;
  logic [DATA_WIDTH-1:0] dwdata_i;
  logic l15_req_valid_o, l15_req_ready_i;
  l15_rqtype_e l15_req_type_o;
  port_e l15_req_port_o;
  logic [PADDR_WIDTH-1:0] l15_req_addr_o;
  size_t l15_req_size_o;
  logic [DATA_WIDTH-1:0] l15_req_data_o;
  logic l15_rtrn_valid_i, l15_rtrn_ready_o;
  port_e l15_rtrn_port_i;
  logic [DATA_WIDTH-1:0] l15_rtrn_data_i;
  logic icache_resp_valid_o, dread_resp_valid_o, dread_resp_ready_i;
  logic dwrite_resp_valid_o, dwrite_resp_ready_i;
  logic [DATA_WIDTH-1:0] icache_resp_data_o, dread_resp_data_o;

  // Expected entry is {type, addr, size, data}
  logic [108:0] exp_ic[$];
  logic [108:0] exp_rd[$];
  logic [108:0] exp_wr[$];
  // Outstanding returns of the L1.5 model
  int rt_port[$];
  logic [63:0] rt_data[$];
  int rt_due[$];

  tb_clock_gen i_clock_gen (.clk_o(clk), .reset_o(reset));

  l15_adapter dut_i (.clk_i(clk), .reset_i(reset), .*);

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [127:0] exp, input logic [127:0] act);
    $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
    fail_run("value mismatch");
  endtask

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  function automatic logic [PADDR_WIDTH-1:0] rand_addr();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[PADDR_WIDTH-1:0];
  endfunction

  function automatic int pending(input int p);
    case (p)
      0: return exp_ic.size();
      1: return exp_rd.size();
      default: return exp_wr.size();
    endcase
  endfunction

  function automatic logic [108:0] pop_expected(input int p);
    case (p)
      0: return exp_ic.pop_front();
      1: return exp_rd.pop_front();
      default: return exp_wr.pop_front();
    endcase
  endfunction

  task automatic run_icache();
    repeat (NUM_TXN) begin
      repeat (rand_below(MAX_GAP)) @(negedge clk);
      icache_miss_valid_i = 1'b1;
      icache_miss_paddr_i = rand_addr();
      do @(posedge clk); while (!icache_miss_ready_o);
      @(negedge clk);
      icache_miss_valid_i = 1'b0;
    end
  endtask

  task automatic run_dread();
    repeat (NUM_TXN) begin
      repeat (rand_below(MAX_GAP)) @(negedge clk);
      dread_valid_i = 1'b1;
      dread_addr_i = rand_addr();
      dread_size_i = size_t'(rand_below(4));
      do @(posedge clk); while (!dread_ready_o);
      @(negedge clk);
      dread_valid_i = 1'b0;
    end
  endtask

  // Request and data are raised on different falling edges, in random order
  task automatic run_dwrite();
    logic data_first;
    repeat (NUM_TXN) begin
      repeat (rand_below(MAX_GAP)) @(negedge clk);
      data_first = rand_below(2);
      dwrite_addr_i = rand_addr();
      dwrite_size_i = size_t'(rand_below(4));
      dwdata_i = {$random(seed), $random(seed)};
      if (data_first) dwdata_valid_i = 1'b1;
      else dwrite_valid_i = 1'b1;
      repeat (1 + rand_below(3)) @(negedge clk);
      dwrite_valid_i = 1'b1;
      dwdata_valid_i = 1'b1;
      do @(posedge clk); while (!dwrite_ready_o);
      @(negedge clk);
      dwrite_valid_i = 1'b0;
      dwdata_valid_i = 1'b0;
    end
  endtask

  // L1.5 model and response readies driven on the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      l15_req_ready_i = (rand_below(4) == 0);
      dread_resp_ready_i = rand_below(2);
      dwrite_resp_ready_i = rand_below(2);
      if (!l15_rtrn_valid_i || rtrn_taken) begin
        rtrn_taken = 1'b0;
        l15_rtrn_valid_i = (rt_port.size() != 0) && (rt_due[0] <= cycle);
        if (l15_rtrn_valid_i) begin
          l15_rtrn_port_i = port_e'(rt_port[0]);
          l15_rtrn_data_i = rt_data[0];
        end
      end
    end
  end

  always @(posedge clk) begin
    int exp_port;
    int p;
    logic issue;
    logic port_ready;
    logic [108:0] e;
    cycle++;
    if (reset || was_reset) begin
      assert (!l15_req_valid_o) else fail_value("l15_req_valid_o", 0, l15_req_valid_o);
    end
    was_reset = reset;
    assert (dwrite_ready_o == dwdata_ready_o)
      else fail_value("dwdata_ready_o", dwrite_ready_o, dwdata_ready_o);
    if (reset) begin
      rr_ptr = 0;
    end else begin
      // Slot occupancy equals the count of accepted but unissued requests
      assert (l15_req_valid_o == (pending(0) + pending(1) + pending(2) != 0))
        else fail_value("l15_req_valid_o", !l15_req_valid_o, l15_req_valid_o);
      exp_port = rr_ptr;
      for (int k = NUM_PORTS - 1; k >= 0; k--) begin
        if (pending((rr_ptr + k) % NUM_PORTS) != 0) exp_port = (rr_ptr + k) % NUM_PORTS;
      end
      issue = l15_req_valid_o && l15_req_ready_i;
      if (l15_req_valid_o) begin
        assert (int'(l15_req_port_o) == exp_port)
          else fail_value("l15_req_port_o", exp_port, l15_req_port_o);
      end
      // A full slot blocks its source until it is issued
      assert (icache_miss_ready_o == (pending(0) == 0 || (issue && exp_port == 0)))
        else fail_value("icache_miss_ready_o", !icache_miss_ready_o, icache_miss_ready_o);
      assert (dread_ready_o == (pending(1) == 0 || (issue && exp_port == 1)))
        else fail_value("dread_ready_o", !dread_ready_o, dread_ready_o);
      if (dwrite_valid_i && dwdata_valid_i) begin
        assert (dwrite_ready_o == (pending(2) == 0 || (issue && exp_port == 2)))
          else fail_value("dwrite_ready_o", !dwrite_ready_o, dwrite_ready_o);
      end
      if (issue) begin
        e = pop_expected(exp_port);
        assert (l15_req_type_o == e[108:107])
          else fail_value("l15_req_type_o", e[108:107], l15_req_type_o);
        assert (l15_req_addr_o == e[106:67])
          else fail_value("l15_req_addr_o", e[106:67], l15_req_addr_o);
        assert (l15_req_size_o == e[66:64])
          else fail_value("l15_req_size_o", e[66:64], l15_req_size_o);
        assert (l15_req_data_o == e[63:0])
          else fail_value("l15_req_data_o", e[63:0], l15_req_data_o);
        rt_port.push_back(exp_port);
        rt_data.push_back({24'h0, l15_req_addr_o} ^ RTRN_KEY);
        rt_due.push_back(cycle + 1 + rand_below(MAX_DELAY));
        rr_ptr = (exp_port + 1) % NUM_PORTS;
      end
      if (icache_miss_valid_i && icache_miss_ready_o)
        exp_ic.push_back({RQ_IFILL, icache_miss_paddr_i[PADDR_WIDTH-1:5], 5'b0, 3'd5, 64'h0});
      if (dread_valid_i && dread_ready_o)
        exp_rd.push_back({RQ_LOAD, dread_addr_i, dread_size_i, 64'h0});
      if (dwrite_valid_i && dwdata_valid_i && dwrite_ready_o)
        exp_wr.push_back({RQ_STORE, dwrite_addr_i, dwrite_size_i, dwdata_i});
      if (l15_rtrn_valid_i) begin
        p = int'(l15_rtrn_port_i);
        port_ready = (p == 0) || (p == 1 && dread_resp_ready_i) ||
                     (p == 2 && dwrite_resp_ready_i);
        assert (l15_rtrn_ready_o == port_ready)
          else fail_value("l15_rtrn_ready_o", port_ready, l15_rtrn_ready_o);
        assert (icache_resp_valid_o == (p == 0))
          else fail_value("icache_resp_valid_o", p == 0, icache_resp_valid_o);
        assert (dread_resp_valid_o == (p == 1 && dread_resp_ready_i))
          else fail_value("dread_resp_valid_o", p == 1 && dread_resp_ready_i, dread_resp_valid_o);
        assert (dwrite_resp_valid_o == (p == 2 && dwrite_resp_ready_i))
          else fail_value("dwrite_resp_valid_o", p == 2 && dwrite_resp_ready_i, dwrite_resp_valid_o);
        if (p == 0) begin
          assert (icache_resp_data_o == rt_data[0])
            else fail_value("icache_resp_data_o", rt_data[0], icache_resp_data_o);
        end
        if (p == 1 && port_ready) begin
          assert (dread_resp_data_o == rt_data[0])
            else fail_value("dread_resp_data_o", rt_data[0], dread_resp_data_o);
        end
        if (port_ready) begin
          rtrn_taken = 1'b1;
          void'(rt_port.pop_front());
          void'(rt_data.pop_front());
          void'(rt_due.pop_front());
        end
      end else begin
        // No return on offer, so every response valid stays low
        assert (!icache_resp_valid_o)
          else fail_value("icache_resp_valid_o", 0, icache_resp_valid_o);
        assert (!dread_resp_valid_o)
          else fail_value("dread_resp_valid_o", 0, dread_resp_valid_o);
        assert (!dwrite_resp_valid_o)
          else fail_value("dwrite_resp_valid_o", 0, dwrite_resp_valid_o);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("Watchdog expired before all requests and returns completed");
  end

  initial begin
    icache_miss_valid_i = 1'b0;
    icache_miss_paddr_i = '0;
    dread_valid_i = 1'b0;
    dread_addr_i = '0;
    dread_size_i = '0;
    dwrite_valid_i = 1'b0;
    dwrite_addr_i = '0;
    dwrite_size_i = '0;
    dwdata_valid_i = 1'b0;
    dwdata_i = '0;
    l15_req_ready_i = 1'b0;
    l15_rtrn_valid_i = 1'b0;
    l15_rtrn_port_i = PORT_ICACHE;
    l15_rtrn_data_i = '0;
    dread_resp_ready_i = 1'b0;
    dwrite_resp_ready_i = 1'b0;
    @(negedge reset);
    fork
      run_icache();
      run_dread();
      run_dwrite();
    join
    while (pending(0) + pending(1) + pending(2) != 0 || rt_port.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- tests/tb_clock_gen.sv
// Free-running 4 ns clock; reset held high over the first 4 rising edges, released on a falling edge
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule
